// ==== src/opipe_pkg.sv ====
/* opipe shared definitions */
package opipe_pkg;

   localparam int DATA_W   = 32;
   localparam int RF_AW    = 5;
   localparam int RF_WORDS = 32;
   localparam int OP_W     = 6;
   localparam int IMM_W    = 16;

   // opcode 0 is left unused, so an all-zero word never writes
   localparam logic [OP_W-1:0] OP_ADD  = 6'h01;
   localparam logic [OP_W-1:0] OP_SUB  = 6'h02;
   localparam logic [OP_W-1:0] OP_AND  = 6'h03;
   localparam logic [OP_W-1:0] OP_OR   = 6'h04;
   localparam logic [OP_W-1:0] OP_XOR  = 6'h05;
   localparam logic [OP_W-1:0] OP_ADDI = 6'h06;
   localparam logic [OP_W-1:0] OP_LUI  = 6'h07;

   // register form, rd = ra op rb
   typedef struct packed {
      logic [OP_W-1:0]                   opcode;
      logic [RF_AW-1:0]                  rd;
      logic [RF_AW-1:0]                  ra;
      logic [RF_AW-1:0]                  rb;
      logic [DATA_W-OP_W-3*RF_AW-1:0]    spare;
   } instr_r_t;

   // immediate form, the low half carries the constant
   typedef struct packed {
      logic [OP_W-1:0]  opcode;
      logic [RF_AW-1:0] rd;
      logic [RF_AW-1:0] ra;
      logic [IMM_W-1:0] imm;
   } instr_i_t;

   // opcode, rd and ra sit at the same bits in both views
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

endpackage

// ==== src/rf_ram.sv ====
/* register RAM bank */
`timescale 1ns/1ps

module rf_ram import opipe_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic [RF_AW-1:0]  rdad_i,
   input  logic              rden_i,
   output logic [DATA_W-1:0] rdda_o,
   input  logic [RF_AW-1:0]  wrad_i,
   input  logic              wren_i,
   input  logic [DATA_W-1:0] wrda_i
);

   logic [DATA_W-1:0] mem [RF_WORDS];
   logic              wr_ok;

   // register 0 is never stored
   assign wr_ok = wren_i & (wrad_i != '0);

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wrad_i] <= wrda_i;
      end
   end

   // read output holds until the next enabled read
   always_ff @(posedge clk) begin
      if (rden_i) begin
         if (rdad_i == '0) begin
            rdda_o <= '0;
         end else if (wr_ok && (wrad_i == rdad_i)) begin
            // same-edge write wins over the stored word
            rdda_o <= wrda_i;
         end else begin
            rdda_o <= mem[rdad_i];
         end
      end
   end

   wren_known_a: assert property (@(posedge clk) disable iff (rst)
      !$isunknown(wren_i));

endmodule

// ==== src/rf_bypass.sv ====
/* register file with result forwarding */
`timescale 1ns/1ps

module rf_bypass import opipe_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              padv_decode_i,
   input  logic [RF_AW-1:0]  decode_rfa_adr_i,
   input  logic [RF_AW-1:0]  decode_rfb_adr_i,
   input  logic [RF_AW-1:0]  execute_rfd_adr_i,
   input  logic              execute_rf_wb_i,
   input  logic [RF_AW-1:0]  ctrl_rfd_adr_i,
   input  logic              ctrl_rf_wb_i,
   input  logic [DATA_W-1:0] ctrl_result_i,
   input  logic [RF_AW-1:0]  wb_rfd_adr_i,
   input  logic              wb_rf_wb_i,
   input  logic [DATA_W-1:0] result_i,
   output logic [DATA_W-1:0] execute_rfa_o,
   output logic [DATA_W-1:0] execute_rfb_o
);

   logic [RF_AW-1:0]  dec_rfa_adr;
   logic [RF_AW-1:0]  dec_rfb_adr;
   logic [DATA_W-1:0] rfa_ram;
   logic [DATA_W-1:0] rfb_ram;
   logic [DATA_W-1:0] ex_rfa_ram;
   logic [DATA_W-1:0] ex_rfb_ram;
   logic [DATA_W-1:0] wb_last_result;
   logic              ex_hz_a;
   logic              ex_hz_b;
   logic              ctrl_hz_a;
   logic              ctrl_hz_b;
   logic              wb_hz_a;
   logic              wb_hz_b;

   // read addresses of the instruction now in decode
   always_ff @(posedge clk) begin
      if (padv_decode_i) begin
         dec_rfa_adr <= decode_rfa_adr_i;
         dec_rfb_adr <= decode_rfb_adr_i;
      end
   end

   // on the decode to execute move, note which writers in flight match;
   // each of them sits one stage further on while the operand is consumed
   always_ff @(posedge clk) begin
      if (rst) begin
         ex_hz_a   <= 1'b0;
         ex_hz_b   <= 1'b0;
         ctrl_hz_a <= 1'b0;
         ctrl_hz_b <= 1'b0;
         wb_hz_a   <= 1'b0;
         wb_hz_b   <= 1'b0;
      end else begin
         ex_hz_a   <= execute_rf_wb_i & (execute_rfd_adr_i == dec_rfa_adr);
         ex_hz_b   <= execute_rf_wb_i & (execute_rfd_adr_i == dec_rfb_adr);
         ctrl_hz_a <= ctrl_rf_wb_i & (ctrl_rfd_adr_i == dec_rfa_adr);
         ctrl_hz_b <= ctrl_rf_wb_i & (ctrl_rfd_adr_i == dec_rfb_adr);
         wb_hz_a   <= wb_rf_wb_i & (wb_rfd_adr_i == dec_rfa_adr);
         wb_hz_b   <= wb_rf_wb_i & (wb_rfd_adr_i == dec_rfb_adr);
      end
   end

   // RAM words read at acceptance, held for the execute cycle
   // since a following acceptance reads the banks again
   always_ff @(posedge clk) begin
      ex_rfa_ram     <= rfa_ram;
      ex_rfb_ram     <= rfb_ram;
      wb_last_result <= result_i;
   end

   // newest source first: ctrl, writeback, last write, RAM
   assign execute_rfa_o = ex_hz_a   ? ctrl_result_i :
                          ctrl_hz_a ? result_i :
                          wb_hz_a   ? wb_last_result :
                          ex_rfa_ram;

   assign execute_rfb_o = ex_hz_b   ? ctrl_result_i :
                          ctrl_hz_b ? result_i :
                          wb_hz_b   ? wb_last_result :
                          ex_rfb_ram;

   rf_ram rfa (
      .clk    (clk),
      .rst    (rst),
      .rdad_i (decode_rfa_adr_i),
      .rden_i (padv_decode_i),
      .rdda_o (rfa_ram),
      .wrad_i (wb_rfd_adr_i),
      .wren_i (wb_rf_wb_i),
      .wrda_i (result_i)
   );

   rf_ram rfb (
      .clk    (clk),
      .rst    (rst),
      .rdad_i (decode_rfb_adr_i),
      .rden_i (padv_decode_i),
      .rdda_o (rfb_ram),
      .wrad_i (wb_rfd_adr_i),
      .wren_i (wb_rf_wb_i),
      .wrda_i (result_i)
   );

   // writers never carry rd 0, so register 0 always comes from the RAM
   no_hz_a_r0_a: assert property (@(posedge clk) disable iff (rst)
      (ex_hz_a | ctrl_hz_a | wb_hz_a) |-> ($past(dec_rfa_adr) != '0));
   no_hz_b_r0_a: assert property (@(posedge clk) disable iff (rst)
      (ex_hz_b | ctrl_hz_b | wb_hz_b) |-> ($past(dec_rfb_adr) != '0));

endmodule

// ==== src/op_decode.sv ====
/* decode stage */
`timescale 1ns/1ps

module op_decode import opipe_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid_i,
   input  logic [DATA_W-1:0] in_instr_i,
   output logic              in_ready_o,
   output logic              padv_o,
   output logic [RF_AW-1:0]  rfa_adr_o,
   output logic [RF_AW-1:0]  rfb_adr_o,
   output logic [RF_AW-1:0]  rfd_adr_o,
   output logic              rf_wb_o,
   output logic [OP_W-1:0]   op_o,
   output logic [IMM_W-1:0]  imm_o
);

   instr_u instr;
   logic   op_known;
   logic   op_imm;

   assign instr = in_instr_i;

   assign op_known = instr.r.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                            OP_XOR, OP_ADDI, OP_LUI};
   assign op_imm   = instr.r.opcode inside {OP_ADDI, OP_LUI};

   // no back-pressure, the core takes a word every cycle out of reset
   assign in_ready_o = ~rst;
   assign padv_o     = in_valid_i & in_ready_o;

   // read addresses go straight to the RAM, which latches them on padv_o;
   // immediate forms point port B at register 0
   assign rfa_adr_o = instr.r.ra;
   assign rfb_adr_o = op_imm ? '0 : instr.r.rb;

   always_ff @(posedge clk) begin
      op_o      <= instr.r.opcode;
      rfd_adr_o <= instr.r.rd;
      imm_o     <= instr.i.imm;
   end

   // bubbles, unknown opcodes and rd 0 all turn into no write
   always_ff @(posedge clk) begin
      if (rst) begin
         rf_wb_o <= 1'b0;
      end else begin
         rf_wb_o <= padv_o & op_known & (instr.r.rd != '0);
      end
   end

endmodule

// ==== src/op_alu.sv ====
/* execute ALU with ctrl and writeback stages */
`timescale 1ns/1ps

module op_alu import opipe_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              ex_valid_i,
   input  logic [OP_W-1:0]   op_i,
   input  logic [RF_AW-1:0]  rd_i,
   input  logic [IMM_W-1:0]  imm_i,
   input  logic [DATA_W-1:0] rfa_i,
   input  logic [DATA_W-1:0] rfb_i,
   output logic [RF_AW-1:0]  ex_rd_o,
   output logic              ex_wb_o,
   output logic [RF_AW-1:0]  ctrl_rd_o,
   output logic              ctrl_wb_o,
   output logic [DATA_W-1:0] ctrl_result_o,
   output logic [RF_AW-1:0]  wb_rd_o,
   output logic              wb_wb_o,
   output logic [DATA_W-1:0] wb_result_o
);

   logic [OP_W-1:0]   ex_op;
   logic [IMM_W-1:0]  ex_imm;
   logic [DATA_W-1:0] imm_sext;
   logic [DATA_W-1:0] alu_result;

   assign imm_sext = {{(DATA_W-IMM_W){ex_imm[IMM_W-1]}}, ex_imm};

   // operands arrive from the forwarding mux during the execute cycle
   always_comb begin
      case (ex_op)
         OP_ADD:  alu_result = rfa_i + rfb_i;
         OP_SUB:  alu_result = rfa_i - rfb_i;
         OP_AND:  alu_result = rfa_i & rfb_i;
         OP_OR:   alu_result = rfa_i | rfb_i;
         OP_XOR:  alu_result = rfa_i ^ rfb_i;
         OP_ADDI: alu_result = rfa_i + imm_sext;
         OP_LUI:  alu_result = {ex_imm, {(DATA_W-IMM_W){1'b0}}};
         default: alu_result = '0;
      endcase
   end

   // stage payload
   always_ff @(posedge clk) begin
      ex_op         <= op_i;
      ex_imm        <= imm_i;
      ex_rd_o       <= rd_i;
      ctrl_rd_o     <= ex_rd_o;
      ctrl_result_o <= alu_result;
      wb_rd_o       <= ctrl_rd_o;
      wb_result_o   <= ctrl_result_o;
   end

   // write flags move one stage per edge, the pipeline never holds
   always_ff @(posedge clk) begin
      if (rst) begin
         ex_wb_o   <= 1'b0;
         ctrl_wb_o <= 1'b0;
         wb_wb_o   <= 1'b0;
      end else begin
         ex_wb_o   <= ex_valid_i;
         ctrl_wb_o <= ex_wb_o;
         wb_wb_o   <= ctrl_wb_o;
      end
   end

   // decode drops rd 0 before any flag is raised
   ctrl_rd_nz_a: assert property (@(posedge clk) disable iff (rst)
      ctrl_wb_o |-> (ctrl_rd_o != '0));

endmodule

// ==== src/opipe_top.sv ====
/* opipe operand pipeline */
`timescale 1ns/1ps

module opipe_top import opipe_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid_i,
   input  logic [DATA_W-1:0] in_instr_i,
   output logic              in_ready_o,
   output logic              wb_valid_o,
   output logic [RF_AW-1:0]  wb_rd_o,
   output logic [DATA_W-1:0] wb_data_o
);

   // decode side
   logic              dec_padv;
   logic [RF_AW-1:0]  dec_ra;
   logic [RF_AW-1:0]  dec_rb;
   logic [RF_AW-1:0]  dec_rd;
   logic              dec_wb;
   logic [OP_W-1:0]   dec_op;
   logic [IMM_W-1:0]  dec_imm;

   // forwarded operands
   logic [DATA_W-1:0] ex_rfa;
   logic [DATA_W-1:0] ex_rfb;

   // stage writers
   logic [RF_AW-1:0]  ex_rd;
   logic              ex_wb;
   logic [RF_AW-1:0]  ctrl_rd;
   logic              ctrl_wb;
   logic [DATA_W-1:0] ctrl_result;
   logic [RF_AW-1:0]  wb_rd;
   logic              wb_wb;
   logic [DATA_W-1:0] wb_result;

   op_decode decode (
      .clk        (clk),
      .rst        (rst),
      .in_valid_i (in_valid_i),
      .in_instr_i (in_instr_i),
      .in_ready_o (in_ready_o),
      .padv_o     (dec_padv),
      .rfa_adr_o  (dec_ra),
      .rfb_adr_o  (dec_rb),
      .rfd_adr_o  (dec_rd),
      .rf_wb_o    (dec_wb),
      .op_o       (dec_op),
      .imm_o      (dec_imm)
   );

   rf_bypass rf (
      .clk               (clk),
      .rst               (rst),
      .padv_decode_i     (dec_padv),
      .decode_rfa_adr_i  (dec_ra),
      .decode_rfb_adr_i  (dec_rb),
      .execute_rfd_adr_i (ex_rd),
      .execute_rf_wb_i   (ex_wb),
      .ctrl_rfd_adr_i    (ctrl_rd),
      .ctrl_rf_wb_i      (ctrl_wb),
      .ctrl_result_i     (ctrl_result),
      .wb_rfd_adr_i      (wb_rd),
      .wb_rf_wb_i        (wb_wb),
      .result_i          (wb_result),
      .execute_rfa_o     (ex_rfa),
      .execute_rfb_o     (ex_rfb)
   );

   op_alu alu (
      .clk           (clk),
      .rst           (rst),
      .ex_valid_i    (dec_wb),
      .op_i          (dec_op),
      .rd_i          (dec_rd),
      .imm_i         (dec_imm),
      .rfa_i         (ex_rfa),
      .rfb_i         (ex_rfb),
      .ex_rd_o       (ex_rd),
      .ex_wb_o       (ex_wb),
      .ctrl_rd_o     (ctrl_rd),
      .ctrl_wb_o     (ctrl_wb),
      .ctrl_result_o (ctrl_result),
      .wb_rd_o       (wb_rd),
      .wb_wb_o       (wb_wb),
      .wb_result_o   (wb_result)
   );

   // every register write is also the visible writeback
   assign wb_valid_o = wb_wb;
   assign wb_rd_o    = wb_rd;
   assign wb_data_o  = wb_result;

endmodule

// ==== tests/opipe_tb.sv ====
/* opipe testbench */
`timescale 1ns/1ps

module opipe_tb import opipe_pkg::*; ();

   localparam int CLK_NS  = 20;
   localparam int N_TESTS = 5;
   localparam int N_RAND  = 200;
   localparam int TBL_MAX = 512;

   logic              clk = 1'b0;
   logic              rst;
   logic              in_valid;
   logic [DATA_W-1:0] in_instr;
   logic              in_ready;
   logic              wb_valid;
   logic [RF_AW-1:0]  wb_rd;
   logic [DATA_W-1:0] wb_data;

   // stimulus table with the expected columns the model fills at acceptance
   logic [DATA_W-1:0] tbl_instr [TBL_MAX];
   int                tbl_gap   [TBL_MAX];
   int                tbl_test  [TBL_MAX];
   logic [DATA_W-1:0] tbl_exp   [TBL_MAX];
   int                tbl_cyc   [TBL_MAX];
   int                tbl_len = 0;
   logic              table_ready = 1'b0;

   logic [DATA_W-1:0] model_rf [RF_WORDS];
   int                exp_q [$];
   int                cyc = 0;
   int                errors = 0;
   int                mon_idx;
   instr_u            mon_instr;
   logic [15:0]       lfsr = 16'd22151;
   string             test_name [N_TESTS] = '{"reset and independent ops", "forwarding",
                                             "immediate forms", "register 0", "random stream"};

   opipe_top dut_i (
      .clk        (clk),
      .rst        (rst),
      .in_valid_i (in_valid),
      .in_instr_i (in_instr),
      .in_ready_o (in_ready),
      .wb_valid_o (wb_valid),
      .wb_rd_o    (wb_rd),
      .wb_data_o  (wb_data)
   );

   always #(CLK_NS / 2) clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[14:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [DATA_W-1:0] reg_form(input logic [OP_W-1:0] op,
                                                  input int rd, input int ra, input int rb);
      instr_u u;
      u.r.opcode = op;
      u.r.rd     = 5'(rd);
      u.r.ra     = 5'(ra);
      u.r.rb     = 5'(rb);
      u.r.spare  = '0;
      return u;
   endfunction

   function automatic logic [DATA_W-1:0] imm_form(input logic [OP_W-1:0] op,
                                                  input int rd, input int ra,
                                                  input logic [15:0] imm);
      instr_u u;
      u.i.opcode = op;
      u.i.rd     = 5'(rd);
      u.i.ra     = 5'(ra);
      u.i.imm    = imm;
      return u;
   endfunction

   function automatic logic [OP_W-1:0] opcode_for(input logic [2:0] sel);
      case (sel)
         3'd1: return OP_ADD;
         3'd2: return OP_SUB;
         3'd3: return OP_AND;
         3'd4: return OP_OR;
         3'd5: return OP_XOR;
         3'd6: return OP_ADDI;
         3'd7: return OP_LUI;
         default: return 6'h3f;
      endcase
   endfunction

   // expected result by the instruction set rules
   function automatic logic [DATA_W-1:0] model_result(input instr_u u,
                                                      input logic [DATA_W-1:0] a,
                                                      input logic [DATA_W-1:0] b);
      case (u.r.opcode)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_ADDI: return a + {{16{u.i.imm[15]}}, u.i.imm};
         OP_LUI:  return {u.i.imm, 16'h0000};
         default: return '0;
      endcase
   endfunction

   task automatic add_row(input int test, input int gap, input logic [DATA_W-1:0] instr);
      tbl_instr[tbl_len] = instr;
      tbl_gap[tbl_len]   = gap;
      tbl_test[tbl_len]  = test;
      tbl_len++;
   endtask

   task automatic build_table();
      instr_u          u;
      logic [OP_W-1:0] op;
      int              g;
      // every register gets a value before anything reads it
      for (int r = 1; r < RF_WORDS; r++) begin
         add_row(1, 0, imm_form(OP_ADDI, r, 0, 16'(r * 16'h0721) ^ 16'h5a5a));
      end
      add_row(1, 0, reg_form(OP_ADD, 10, 20, 21));
      add_row(1, 0, reg_form(OP_SUB, 11, 22, 23));
      add_row(1, 0, reg_form(OP_AND, 12, 24, 25));
      add_row(1, 0, reg_form(OP_OR, 13, 26, 27));
      add_row(1, 0, reg_form(OP_XOR, 14, 28, 29));
      // dependence distances of 1 to 3 rows with s bubbles before each row
      for (int s = 0; s < 4; s++) begin
         add_row(2, s, imm_form(OP_ADDI, 5, 5, 16'(s + 1)));
         add_row(2, s, reg_form(OP_SUB, 7, 5, 3));
         add_row(2, s, reg_form(OP_SUB, 8, 4, 7));
         add_row(2, s, reg_form(OP_ADD, 9, 8, 7));
         add_row(2, s, reg_form(OP_OR, 10, 7, 9));
      end
      add_row(3, 0, imm_form(OP_LUI, 15, 0, 16'h8001));
      add_row(3, 0, imm_form(OP_ADDI, 15, 15, 16'hffff));
      add_row(3, 0, imm_form(OP_ADDI, 16, 15, 16'h7fff));
      add_row(3, 0, imm_form(OP_LUI, 17, 9, 16'hdead));
      add_row(3, 0, imm_form(OP_ADDI, 17, 17, 16'hbeef));
      add_row(3, 0, reg_form(OP_ADD, 18, 17, 16));
      add_row(4, 0, imm_form(OP_ADDI, 0, 0, 16'h1234));
      add_row(4, 0, reg_form(OP_ADD, 0, 1, 2));
      add_row(4, 0, reg_form(OP_ADD, 19, 0, 0));
      add_row(4, 0, reg_form(OP_OR, 20, 0, 3));
      add_row(4, 0, imm_form(OP_LUI, 0, 0, 16'hffff));
      add_row(4, 0, reg_form(OP_SUB, 21, 3, 0));
      add_row(4, 0, reg_form(6'h3f, 22, 1, 2));
      // small register range keeps hazards frequent
      for (int n = 0; n < N_RAND; n++) begin
         op = opcode_for(3'(rand_bits(3)));
         u = imm_form(op, 5'(rand_bits(3)), 5'(rand_bits(3)), 16'h0000);
         if (op inside {OP_ADDI, OP_LUI}) begin
            u.i.imm = rand_bits(16);
         end else begin
            u.r.rb = 5'(rand_bits(3));
         end
         g = rand_bits(2);
         add_row(5, (g > 1) ? g - 1 : 0, u);
      end
   endtask

   // model update in program order with the writeback due 4 counts after the drive
   task automatic accept_row(input int idx);
      instr_u u;
      u = tbl_instr[idx];
      tbl_exp[idx] = model_result(u, model_rf[u.r.ra], model_rf[u.r.rb]);
      tbl_cyc[idx] = cyc + 4;
      if ((u.r.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LUI})
          && (u.r.rd != '0)) begin
         model_rf[u.r.rd] = tbl_exp[idx];
         exp_q.push_back(idx);
      end
   endtask

   task automatic run_test(input int test, inout int failed);
      int first_err;
      first_err = errors;
      for (int i = 0; i < tbl_len; i++) begin
         if (tbl_test[i] == test) begin
            // bubbles carry the next word with valid low
            repeat (tbl_gap[i]) begin
               @(posedge clk);
               #2;
               in_valid = 1'b0;
               in_instr = tbl_instr[i];
            end
            @(posedge clk);
            #2;
            check_value("in_ready_o", in_ready, 1'b1);
            in_valid = 1'b1;
            in_instr = tbl_instr[i];
            accept_row(i);
         end
      end
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (2) @(negedge clk);
      if (errors != first_err) begin
         failed++;
      end
      $display("test %0d %s: %s", test, test_name[test-1],
               (errors == first_err) ? "ok" : "failed");
   endtask

   // writebacks are compared mid-cycle against the queued rows in order
   always @(negedge clk) begin
      if (!rst && $isunknown(wb_valid)) begin
         $display("wb_valid_o is unknown at %0d ns", $time);
         errors++;
      end else if (!rst && wb_valid) begin
         if (exp_q.size() == 0) begin
            $display("unexpected writeback to r%0d at %0d ns", wb_rd, $time);
            errors++;
         end else begin
            mon_idx = exp_q.pop_front();
            mon_instr = tbl_instr[mon_idx];
            check_value("wb_rd_o", wb_rd, mon_instr.r.rd);
            check_value("wb_data_o", wb_data, tbl_exp[mon_idx]);
            check_value("writeback cycle", cyc, tbl_cyc[mon_idx]);
         end
      end
   end

   initial begin
      int cycles;
      wait (table_ready);
      cycles = 3 + 10 * N_TESTS + 100;
      for (int i = 0; i < tbl_len; i++) begin
         cycles += 1 + tbl_gap[i];
      end
      #(cycles * CLK_NS);
      $display("timeout: the pipeline did not deliver all writebacks in time");
      $display("** FAIL **");
      $finish;
   end

   initial begin
      int failed;
      failed   = 0;
      rst      = 1'b1;
      in_valid = 1'b0;
      in_instr = '0;
      foreach (model_rf[r]) model_rf[r] = '0;
      build_table();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      check_value("in_ready_o in reset", in_ready, 1'b0);
      #2;
      rst = 1'b0;
      for (int t = 1; t <= N_TESTS; t++) begin
         run_test(t, failed);
      end
      $display("tests passed %0d, failed %0d, errors %0d", N_TESTS - failed, failed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== opipe.f ====
src/opipe_pkg.sv
src/rf_ram.sv
src/rf_bypass.sv
src/op_decode.sv
src/op_alu.sv
src/opipe_top.sv
tests/opipe_tb.sv

// ==== Bender.yml ====
package:
  name: opipe

sources:
  - src/opipe_pkg.sv
  - src/rf_ram.sv
  - src/rf_bypass.sv
  - src/op_decode.sv
  - src/op_alu.sv
  - src/opipe_top.sv
  - target: test
    files:
      - tests/opipe_tb.sv
